//--- hdl/spiPkg.sv
package spiPkg;

  // Register field widths
  typedef logic [11:0] sckDivT;
  typedef logic [1:0]  sckModeT;
  typedef logic [1:0]  csModeT;
  typedef logic [15:0] delayT;
  typedef logic [7:0]  frameT;

  // APB side
  typedef logic [7:0]  apbAddrT;
  typedef logic [31:0] apbDataT;

  // Chip select modes
  localparam csModeT CsAuto = 2'b00;
  localparam csModeT CsHold = 2'b10;
  localparam csModeT CsOff  = 2'b11;

  // Register map, byte offsets
  localparam apbAddrT AddrSckDiv  = 8'h00;
  localparam apbAddrT AddrSckMode = 8'h04;
  localparam apbAddrT AddrCsMode  = 8'h18;
  localparam apbAddrT AddrDelay0  = 8'h28;
  localparam apbAddrT AddrDelay1  = 8'h2C;
  localparam apbAddrT AddrTxData  = 8'h48;
  localparam apbAddrT AddrRxData  = 8'h4C;
  localparam apbAddrT AddrStatus  = 8'h50;

  // Transmit FIFO sizing
  localparam int TxFifoDepth = 8;
  // Pointer wraps naturally, depth is a power of two
  typedef logic [$clog2(TxFifoDepth)-1:0] txPtrT;
  // One extra bit so full is representable
  typedef logic [$clog2(TxFifoDepth):0]   txCountT;

endpackage

//--- hdl/spiRegs.sv
`timescale 1ns/10ps

module spiRegs (
  input  logic             PCLK,
  input  logic             PRESETn,
  // APB slave port
  input  logic             PSEL,
  input  logic             PENABLE,
  input  logic             PWRITE,
  input  spiPkg::apbAddrT  PADDR,
  input  spiPkg::apbDataT  PWDATA,
  output spiPkg::apbDataT  PRDATA,
  output logic             PREADY,
  // Peripheral status
  input  logic             txFull,
  input  logic             txEmpty,
  input  logic             InactiveState,
  input  spiPkg::frameT    rxByte,
  input  logic             rxDone,
  // Configuration levels
  output spiPkg::sckDivT   SckDiv,
  output spiPkg::sckModeT  SckMode,
  output spiPkg::csModeT   CsMode,
  output spiPkg::delayT    Delay0,
  output spiPkg::delayT    Delay1,
  // Transmit path
  output logic             txPush,
  output spiPkg::frameT    txPushData,
  output logic             TransmitStart,
  output logic             TransmitStartD,
  output logic             ResetSCLKenable
);

  logic          apbWrite;
  logic          apbRead;
  logic          startNow;
  logic          startWait;
  logic          rxValid;
  spiPkg::frameT rxData;

  // Zero wait states, access phase always completes
  assign PREADY   = 1'b1;
  assign apbWrite = PSEL & PENABLE & PWRITE;
  assign apbRead  = PSEL & PENABLE & ~PWRITE;

  // Push into FIFO, dropped when full
  assign txPush     = apbWrite & (PADDR == spiPkg::AddrTxData) & ~txFull;
  assign txPushData = PWDATA[7:0];
  // Restart divider whenever it changes
  assign ResetSCLKenable = apbWrite & (PADDR == spiPkg::AddrSckDiv);

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      SckDiv  <= 12'd3;
      SckMode <= 2'b00;
      CsMode  <= spiPkg::CsAuto;
      Delay0  <= 16'd0;
      Delay1  <= 16'd0;
    end else if (apbWrite) begin
      case (PADDR)
        spiPkg::AddrSckDiv:  SckDiv  <= PWDATA[11:0];
        spiPkg::AddrSckMode: SckMode <= PWDATA[1:0];
        spiPkg::AddrCsMode:  CsMode  <= PWDATA[1:0];
        spiPkg::AddrDelay0:  Delay0  <= PWDATA[15:0];
        spiPkg::AddrDelay1:  Delay1  <= PWDATA[15:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Start pulses
  ////////////////////////////////////////////////////////////////////////////

  // Kick an idle controller on a fresh push or on a leftover byte
  assign startNow = InactiveState & ~startWait & (txPush | ~txEmpty);

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      TransmitStart  <= 1'b0;
      TransmitStartD <= 1'b0;
      startWait      <= 1'b0;
    end else begin
      TransmitStart  <= startNow;
      TransmitStartD <= TransmitStart;
      // Block repeats until the controller has left idle
      if (startNow) begin
        startWait <= 1'b1;
      end else if (~InactiveState) begin
        startWait <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive byte and read mux
  ////////////////////////////////////////////////////////////////////////////

  // New byte wins over a clearing read
  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      rxValid <= 1'b0;
    end else if (rxDone) begin
      rxValid <= 1'b1;
    end else if (apbRead & (PADDR == spiPkg::AddrRxData)) begin
      rxValid <= 1'b0;
    end
  end

  always_ff @(posedge PCLK) begin
    if (rxDone) begin
      rxData <= rxByte;
    end
  end

  always_comb begin
    case (PADDR)
      spiPkg::AddrSckDiv:  PRDATA = {20'd0, SckDiv};
      spiPkg::AddrSckMode: PRDATA = {30'd0, SckMode};
      spiPkg::AddrCsMode:  PRDATA = {30'd0, CsMode};
      spiPkg::AddrDelay0:  PRDATA = {16'd0, Delay0};
      spiPkg::AddrDelay1:  PRDATA = {16'd0, Delay1};
      spiPkg::AddrRxData:  PRDATA = {24'd0, rxData};
      // Full, rx valid, idle
      spiPkg::AddrStatus:  PRDATA = {29'd0, InactiveState, rxValid, txFull};
      default:             PRDATA = 32'd0;
    endcase
  end

endmodule

//--- hdl/spiTxFifo.sv
`timescale 1ns/10ps

module spiTxFifo (
  input  logic          PCLK,
  input  logic          PRESETn,
  input  logic          txPush,
  input  spiPkg::frameT txPushData,
  input  logic          txPop,
  output spiPkg::frameT txHead,
  output logic          txEmpty,
  output logic          txFull
);

  spiPkg::frameT   mem [spiPkg::TxFifoDepth];
  spiPkg::txPtrT   wrPtr;
  spiPkg::txPtrT   rdPtr;
  spiPkg::txCountT count;
  logic            doPush;
  logic            doPop;

  // Guard against overflow and underflow
  assign doPush = txPush & ~txFull;
  assign doPop  = txPop & ~txEmpty;

  assign txEmpty = count == '0;
  assign txFull  = count == spiPkg::txCountT'(spiPkg::TxFifoDepth);
  // Head is visible before the pop
  assign txHead  = mem[rdPtr];

  // Storage
  always_ff @(posedge PCLK) begin
    if (doPush) begin
      mem[wrPtr] <= txPushData;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Both or neither, count unchanged
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/spiController.sv
`timescale 1ns/10ps

module spiController (
  input  logic            PCLK,
  input  logic            PRESETn,
  // Start strobes from register block
  input  logic            TransmitStart,
  input  logic            TransmitStartD,
  input  logic            ResetSCLKenable,
  // Configuration
  input  spiPkg::sckDivT  SckDiv,
  input  spiPkg::sckModeT SckMode,
  input  spiPkg::csModeT  CsMode,
  input  spiPkg::delayT   Delay0,
  input  spiPkg::delayT   Delay1,
  input  logic            txEmpty,
  // Timing outputs
  output logic            SCLKenable,
  output logic            ShiftEdge,
  output logic            SampleEdge,
  output logic            EndOfFrame,
  output logic            EndOfFrameDelay,
  output logic            Transmitting,
  output logic            InactiveState,
  output logic            SPICLK,
  output logic            txPop
);

  typedef enum logic [2:0] {
    StInactive, StCsSck, StTransmit, StSckCs, StHold, StInterCs, StInterXfr
  } stateT;

  stateT          currState;
  stateT          nextState;
  spiPkg::sckDivT divCounter;
  // Half-rate clock for delay counting, never driven out
  logic           sck;
  logic [3:0]     edgeCnt;
  logic           lastEdge;
  logic           sampleNow;
  logic           shiftNow;
  logic           startAccept;
  logic           startPend;
  logic           startReq;
  logic           moreData;
  logic           holdMode;
  logic [7:0]     csSck;
  logic [7:0]     sckCs;
  logic [7:0]     interCs;
  logic [7:0]     interXfr;
  logic [7:0]     delayCnt;
  logic [7:0]     delayTarget;
  logic           delayDone;

  // Delay fields
  assign csSck    = Delay0[7:0];
  assign sckCs    = Delay0[15:8];
  assign interCs  = Delay1[7:0];
  assign interXfr = Delay1[15:8];

  assign holdMode = CsMode == spiPkg::CsHold;

  // Starts are honoured only from idle
  assign startAccept = TransmitStart & (currState == StInactive);
  assign startReq    = startPend | (TransmitStartD & (currState == StInactive));

  ////////////////////////////////////////////////////////////////////////////
  // Divider and SPICLK
  ////////////////////////////////////////////////////////////////////////////

  assign SCLKenable = divCounter == SckDiv;
  // 16 edges per frame, even index is the leading edge
  assign lastEdge   = edgeCnt == 4'd15;
  assign EndOfFrame = Transmitting & SCLKenable & lastEdge;

  // Sample when edge parity matches CPHA, shift on the other edge
  assign sampleNow = Transmitting & SCLKenable & (edgeCnt[0] == SckMode[0]);
  // No shift before first bit or after last bit
  assign shiftNow  = Transmitting & SCLKenable & (edgeCnt[0] != SckMode[0]) &
                     ~lastEdge & (edgeCnt != 4'd0);

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      divCounter <= '0;
      SPICLK     <= SckMode[1];
      sck        <= 1'b0;
      edgeCnt    <= 4'd0;
      startPend  <= 1'b0;
      moreData   <= 1'b0;
    end else begin
      if (SCLKenable | startAccept | ResetSCLKenable) begin
        divCounter <= '0;
      end else begin
        divCounter <= divCounter + 1'b1;
      end

      if (startAccept) begin
        sck <= 1'b0;
      end else if (SCLKenable) begin
        sck <= ~sck;
      end

      // Idle level outside transmit, 16 toggles bring it back
      if (~Transmitting) begin
        SPICLK <= SckMode[1];
      end else if (SCLKenable) begin
        SPICLK <= ~SPICLK;
      end

      if (~Transmitting) begin
        edgeCnt <= 4'd0;
      end else if (SCLKenable) begin
        edgeCnt <= edgeCnt + 4'd1;
      end

      // Hold the start request until the next divider tick
      if (SCLKenable) begin
        startPend <= 1'b0;
      end else if (TransmitStartD & (currState == StInactive)) begin
        startPend <= 1'b1;
      end

      // Byte popped at frame end still needs sending
      if (EndOfFrame) begin
        moreData <= ~txEmpty;
      end
    end
  end

  // Strobes centred between rising edges
  always_ff @(negedge PCLK) begin
    if (~PRESETn | startAccept) begin
      ShiftEdge       <= 1'b0;
      SampleEdge      <= 1'b0;
      EndOfFrameDelay <= 1'b0;
    end else begin
      ShiftEdge       <= shiftNow;
      SampleEdge      <= sampleNow;
      EndOfFrameDelay <= EndOfFrame;
    end
  end

  // Load on start, reload at frame end when more is queued
  assign txPop = startAccept | (EndOfFrameDelay & ~txEmpty);

  ////////////////////////////////////////////////////////////////////////////
  // Delay counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (currState)
      StCsSck:    delayTarget = csSck;
      StSckCs:    delayTarget = sckCs;
      StInterCs:  delayTarget = interCs;
      StInterXfr: delayTarget = interXfr;
      default:    delayTarget = 8'd0;
    endcase
  end

  // One unit is a full sck period
  assign delayDone = ~sck & (delayCnt == delayTarget);

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      delayCnt <= 8'd0;
    end else if (SCLKenable) begin
      if (nextState != currState) begin
        delayCnt <= 8'd0;
      end else if (sck & (delayTarget != 8'd0)) begin
        delayCnt <= delayCnt + 8'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Chip select FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      currState <= StInactive;
    end else if (SCLKenable) begin
      currState <= nextState;
    end
  end

  always_comb begin
    nextState = currState;
    case (currState)
      StInactive: begin
        if (startReq) begin
          nextState = (csSck != 8'd0) ? StCsSck : StTransmit;
        end
      end
      StCsSck: begin
        if (delayDone) nextState = StTransmit;
      end
      StTransmit: begin
        if (EndOfFrame) begin
          if (holdMode) begin
            // CS stays low between and after frames
            if (txEmpty) nextState = StHold;
            else if (interXfr != 8'd0) nextState = StInterXfr;
          end else if (sckCs != 8'd0) begin
            nextState = StSckCs;
          end else if (txEmpty) begin
            nextState = StInactive;
          end else if (interCs != 8'd0) begin
            nextState = StInterCs;
          end
        end
      end
      StSckCs: begin
        if (delayDone) begin
          if (~moreData) nextState = StInactive;
          else if (interCs != 8'd0) nextState = StInterCs;
          else nextState = StTransmit;
        end
      end
      StHold: begin
        if (~holdMode) nextState = StInactive;
      end
      StInterCs: begin
        if (delayDone) nextState = (csSck != 8'd0) ? StCsSck : StTransmit;
      end
      StInterXfr: begin
        if (delayDone) nextState = StTransmit;
      end
      default: nextState = StInactive;
    endcase
  end

  assign Transmitting  = currState == StTransmit;
  // CS released while idle and during the inter-cs gap
  assign InactiveState = (currState == StInactive) | (currState == StInterCs);

endmodule

//--- hdl/spiShifter.sv
`timescale 1ns/10ps

module spiShifter (
  input  logic          PCLK,
  input  logic          PRESETn,
  // Transmit load
  input  logic          txPop,
  input  spiPkg::frameT txHead,
  // Strobes from the controller
  input  logic          ShiftEdge,
  input  logic          SampleEdge,
  input  logic          EndOfFrameDelay,
  input  logic          Transmitting,
  // Pins
  input  logic          SPIIN,
  output logic          SPIOUT,
  // Received frame
  output spiPkg::frameT rxByte,
  output logic          rxDone
);

  spiPkg::frameT txReg;
  spiPkg::frameT rxReg;
  spiPkg::frameT rxNext;
  logic          doShift;
  logic          doSample;

  assign doShift  = ShiftEdge & Transmitting;
  assign doSample = SampleEdge & Transmitting;

  // MSB first
  assign SPIOUT = txReg[7];
  assign rxNext = {rxReg[6:0], SPIIN};

  // Transmit shift register, cleared so the pin idles low
  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      txReg <= '0;
    end else if (txPop) begin
      txReg <= txHead;
    end else if (doShift) begin
      txReg <= {txReg[6:0], 1'b0};
    end
  end

  // Receive shift register
  always_ff @(posedge PCLK) begin
    if (doSample) begin
      rxReg <= rxNext;
    end
  end

  // Last sample can land on the frame end edge
  always_ff @(posedge PCLK) begin
    if (EndOfFrameDelay) begin
      rxByte <= doSample ? rxNext : rxReg;
    end
  end

  always_ff @(posedge PCLK) begin
    if (~PRESETn) begin
      rxDone <= 1'b0;
    end else begin
      rxDone <= EndOfFrameDelay;
    end
  end

endmodule

//--- hdl/spiPeriph.sv
`timescale 1ns/10ps

module spiPeriph (
  input  logic            PCLK,
  input  logic            PRESETn,
  // APB
  input  logic            PSEL,
  input  logic            PENABLE,
  input  logic            PWRITE,
  input  spiPkg::apbAddrT PADDR,
  input  spiPkg::apbDataT PWDATA,
  output spiPkg::apbDataT PRDATA,
  output logic            PREADY,
  // SPI pins
  input  logic            SPIIN,
  output logic            SPICLK,
  output logic            SPIOUT,
  output logic            SPICS
);

  spiPkg::sckDivT  sckDiv;
  spiPkg::sckModeT sckMode;
  spiPkg::csModeT  csMode;
  spiPkg::delayT   delay0;
  spiPkg::delayT   delay1;
  spiPkg::frameT   txPushData;
  spiPkg::frameT   txHead;
  spiPkg::frameT   rxByte;
  logic            txPush;
  logic            txPop;
  logic            txEmpty;
  logic            txFull;
  logic            transmitStart;
  logic            transmitStartD;
  logic            resetSclkEnable;
  logic            shiftEdge;
  logic            sampleEdge;
  logic            endOfFrameDelay;
  logic            transmitting;
  logic            inactiveState;
  logic            rxDone;

  // Single active-low chip select
  assign SPICS = inactiveState;

  spiRegs spiRegs_i (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY,
    .txFull, .txEmpty, .InactiveState(inactiveState), .rxByte, .rxDone,
    .SckDiv(sckDiv), .SckMode(sckMode), .CsMode(csMode), .Delay0(delay0),
    .Delay1(delay1), .txPush, .txPushData, .TransmitStart(transmitStart),
    .TransmitStartD(transmitStartD), .ResetSCLKenable(resetSclkEnable)
  );

  spiTxFifo spiTxFifo_i (
    .PCLK, .PRESETn, .txPush, .txPushData, .txPop, .txHead, .txEmpty, .txFull
  );

  // Divider tick and undelayed frame end stay internal
  spiController spiController_i (
    .PCLK, .PRESETn, .TransmitStart(transmitStart), .TransmitStartD(transmitStartD),
    .ResetSCLKenable(resetSclkEnable), .SckDiv(sckDiv), .SckMode(sckMode),
    .CsMode(csMode), .Delay0(delay0), .Delay1(delay1), .txEmpty,
    .SCLKenable(), .ShiftEdge(shiftEdge), .SampleEdge(sampleEdge), .EndOfFrame(),
    .EndOfFrameDelay(endOfFrameDelay), .Transmitting(transmitting),
    .InactiveState(inactiveState), .SPICLK, .txPop
  );

  spiShifter spiShifter_i (
    .PCLK, .PRESETn, .txPop, .txHead, .ShiftEdge(shiftEdge), .SampleEdge(sampleEdge),
    .EndOfFrameDelay(endOfFrameDelay), .Transmitting(transmitting), .SPIIN, .SPIOUT,
    .rxByte, .rxDone
  );

endmodule

//--- bench/spiSlaveModel.sv
`timescale 1ns/10ps

module spiSlaveModel (
  input  logic            SPICLK,
  input  logic            SPIOUT,
  input  logic            SPICS,
  input  spiPkg::sckModeT SckMode,
  input  spiPkg::frameT   replyByte,
  output logic            SPIIN,
  output spiPkg::frameT   gotByte,
  output logic            gotStrobe
);

  logic          csLate;
  logic          outLate;
  logic          isLead;
  spiPkg::frameT rxSh;
  spiPkg::frameT curReply;
  int            bitCnt;

  // Chip select seen slightly late, so the final edge still counts
  assign #2 csLate = SPICS;
  // Host data as it was just before each edge
  assign #1 outLate = SPIOUT;

  initial begin
    SPIIN     = 1'b0;
    gotByte   = '0;
    gotStrobe = 1'b0;
    rxSh      = '0;
    curReply  = '0;
    bitCnt    = 0;
  end

  // CPHA 0 needs the MSB before the first edge
  always @(negedge SPICS) begin
    bitCnt   = 0;
    curReply = replyByte;
    if (!SckMode[0]) begin
      SPIIN = curReply[7];
    end
  end

  always @(SPICLK) begin
    if (csLate === 1'b0) begin
      isLead = SPICLK !== SckMode[1];
      if (isLead ^ SckMode[0]) begin
        // Sample edge
        rxSh   = {rxSh[6:0], outLate};
        bitCnt = bitCnt + 1;
        if (bitCnt == 8) begin
          gotByte   = rxSh;
          gotStrobe = 1'b1;
          gotStrobe <= #1 1'b0;
          bitCnt    = 0;
        end
      end else begin
        // Shift edge loads a new reply at each frame boundary
        if (bitCnt == 0) begin
          curReply = replyByte;
        end
        SPIIN = curReply[7 - bitCnt];
      end
    end
  end

endmodule

//--- bench/spiTb.sv
`timescale 1ns/10ps

module spiTb;

  logic            PCLK;
  logic            PRESETn;
  logic            PSEL;
  logic            PENABLE;
  logic            PWRITE;
  spiPkg::apbAddrT PADDR;
  spiPkg::apbDataT PWDATA;
  spiPkg::apbDataT PRDATA;
  logic            PREADY;
  logic            SPIIN;
  logic            SPICLK;
  logic            SPIOUT;
  logic            SPICS;

  spiPkg::sckModeT slaveMode;
  spiPkg::frameT   replyByte;
  spiPkg::frameT   gotByte;
  logic            gotStrobe;

  spiPkg::frameT   expQ[$];
  spiPkg::frameT   expByte;
  int              errCount;
  int              timeoutCount;
  int              framesSeen;
  int              curDiv;
  int              settle;
  int              runLen;
  int              csLowLen;
  logic            runCsLow;
  logic            prevSck;
  logic            delayCheck;
  int unsigned     waitLimit = 20000;

  spiPeriph spiPeriph_i (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY,
    .SPIIN, .SPICLK, .SPIOUT, .SPICS
  );

  spiSlaveModel slave_i (
    .SPICLK, .SPIOUT, .SPICS, .SckMode(slaveMode), .replyByte, .SPIIN, .gotByte,
    .gotStrobe
  );

  initial begin
    PCLK = 1'b0;
    forever #10 PCLK = ~PCLK;
  end

  //////////////////////////////////////////////////////////////////////////
  // Reporting and bus tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic reportValue(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    errCount++;
    $display("** Error %s: expected %h, got %h", name, exp, act);
  endtask

  task automatic reportTimeout(input string what);
    timeoutCount++;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  task automatic apbWrite(input spiPkg::apbAddrT addr, input spiPkg::apbDataT data);
    int i;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    // Access phase ends on the edge that sees PREADY
    for (i = 0; i < 16; i++) begin
      @(posedge PCLK);
      if (PREADY) break;
    end
    if (i == 16) reportTimeout("PREADY on write");
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apbRead(input spiPkg::apbAddrT addr, output spiPkg::apbDataT data);
    int i;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    data = '0;
    for (i = 0; i < 16; i++) begin
      @(posedge PCLK);
      if (PREADY) break;
    end
    if (i == 16) reportTimeout("PREADY on read");
    data = PRDATA;
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic setMode(input spiPkg::sckModeT m);
    apbWrite(spiPkg::AddrSckMode, {30'd0, m});
    slaveMode = m;
    // SPICLK follows the new polarity a cycle later
    settle = 4;
  endtask

  task automatic setDiv(input int d);
    apbWrite(spiPkg::AddrSckDiv, d);
    curDiv = d;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Waits, each with its own cycle limit
  //////////////////////////////////////////////////////////////////////////

  task automatic waitFrames(input int n);
    int i;
    for (i = 0; i < waitLimit; i++) begin
      @(posedge PCLK);
      if (framesSeen >= n) break;
    end
    if (i == waitLimit) reportTimeout("frames at the slave");
  endtask

  task automatic waitCsHigh();
    int i;
    for (i = 0; i < waitLimit; i++) begin
      @(posedge PCLK);
      if (SPICS === 1'b1) break;
    end
    if (i == waitLimit) reportTimeout("SPICS to return high");
  endtask

  task automatic checkRx(input spiPkg::frameT reply);
    spiPkg::apbDataT d;
    int i;
    for (i = 0; i < 200; i++) begin
      apbRead(spiPkg::AddrStatus, d);
      if (d[1]) break;
    end
    if (i == 200) reportTimeout("rx valid");
    apbRead(spiPkg::AddrRxData, d);
    assert (d[7:0] == reply) else reportValue("PRDATA rx byte", reply, d[7:0]);
    apbRead(spiPkg::AddrStatus, d);
    assert (d[1] == 1'b0) else reportValue("PRDATA rx valid", 0, d[1]);
  endtask

  // One frame with a fresh reply, CS mode decides the wait
  task automatic sendFrame(input logic waitCs);
    spiPkg::frameT b;
    spiPkg::frameT r;
    int target;
    b = $urandom;
    r = $urandom;
    replyByte <= r;
    expQ.push_back(b);
    target = framesSeen + 1;
    apbWrite(spiPkg::AddrTxData, {24'd0, b});
    waitFrames(target);
    if (waitCs) begin
      waitCsHigh();
      checkRx(r);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////////

  always @(posedge gotStrobe) begin
    framesSeen++;
    if (expQ.size() == 0) begin
      errCount++;
      $display("Slave received byte %h when none was expected", gotByte);
    end else begin
      expByte = expQ.pop_front();
      assert (gotByte == expByte) else reportValue("slave byte", expByte, gotByte);
    end
  end

  // SPICLK levels, idle level and cs-to-sck gap
  always @(posedge PCLK) begin
    if (PRESETn) begin
      if (SPICLK !== prevSck) begin
        if (runCsLow) begin
          assert (runLen % (curDiv + 1) == 0)
            else reportValue("SPICLK level length", curDiv + 1, runLen);
        end
        if (delayCheck && !SPICS) begin
          assert (csLowLen >= 2 * (curDiv + 1))
            else reportValue("SPICLK cs-to-sck gap", 2 * (curDiv + 1), csLowLen);
        end
        runLen   = 1;
        runCsLow = !SPICS;
      end else begin
        runLen++;
      end
      if (SPICS) begin
        csLowLen = 0;
        runCsLow = 1'b0;
      end else begin
        csLowLen++;
      end
      if (settle > 0) begin
        settle--;
      end else if (SPICS) begin
        assert (SPICLK === slaveMode[1])
          else reportValue("SPICLK idle", slaveMode[1], SPICLK);
      end
      prevSck = SPICLK;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  initial begin
    spiPkg::apbDataT d;
    int base;
    PRESETn    <= 1'b0;
    PSEL       <= 1'b0;
    PENABLE    <= 1'b0;
    PWRITE     <= 1'b0;
    PADDR      <= '0;
    PWDATA     <= '0;
    slaveMode  = 2'b00;
    replyByte  = '0;
    errCount   = 0;
    timeoutCount = 0;
    framesSeen = 0;
    curDiv     = 3;
    settle     = 4;
    runLen     = 0;
    csLowLen   = 0;
    runCsLow   = 1'b0;
    prevSck    = 1'b0;
    delayCheck = 1'b0;
    void'($urandom(32'hce91));
    repeat (2) @(posedge PCLK);
    PRESETn <= 1'b1;

    // All four clock modes in auto CS
    for (int m = 0; m < 4; m++) begin
      setMode(m[1:0]);
      setDiv(1 + $urandom % 3);
      repeat (3) sendFrame(1'b1);
    end

    // Hold mode keeps CS low until auto is restored
    apbWrite(spiPkg::AddrCsMode, {30'd0, spiPkg::CsHold});
    sendFrame(1'b0);
    repeat (40) begin
      @(posedge PCLK);
      assert (SPICS == 1'b0) else reportValue("SPICS in hold", 0, SPICS);
    end
    apbWrite(spiPkg::AddrCsMode, {30'd0, spiPkg::CsAuto});
    waitCsHigh();
    checkRx(replyByte);

    // Nonzero cs-to-sck delay
    apbWrite(spiPkg::AddrDelay0, 1 + $urandom % 3);
    delayCheck = 1'b1;
    sendFrame(1'b1);
    delayCheck = 1'b0;
    apbWrite(spiPkg::AddrDelay0, 0);

    // Burst past the FIFO depth, slow clock so no frame ends inside it
    setDiv(3);
    base = framesSeen;
    for (int i = 0; i < spiPkg::TxFifoDepth + 4; i++) begin
      d = $urandom % 256;
      if (i <= spiPkg::TxFifoDepth) expQ.push_back(d[7:0]);
      apbWrite(spiPkg::AddrTxData, d);
    end
    apbRead(spiPkg::AddrStatus, d);
    assert (d[0] == 1'b1) else reportValue("PRDATA tx full", 1, d[0]);
    waitFrames(base + spiPkg::TxFifoDepth + 1);
    waitCsHigh();
    repeat (200) @(posedge PCLK);
    assert (framesSeen == base + spiPkg::TxFifoDepth + 1)
      else reportValue("frame count", base + spiPkg::TxFifoDepth + 1, framesSeen);
    assert (expQ.size() == 0) else reportValue("bytes not received", 0, expQ.size());

    $display("Checks done with %0d errors and %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Whole-run limit
  initial begin
    #5ms;
    $display("Simulation ran past its time limit");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- spiPeriph.f
hdl/spiPkg.sv
hdl/spiRegs.sv
hdl/spiTxFifo.sv
hdl/spiController.sv
hdl/spiShifter.sv
hdl/spiPeriph.sv
bench/spiSlaveModel.sv
bench/spiTb.sv

//--- Bender.yml
package:
  name: spiPeriph

sources:
  - files:
      - hdl/spiPkg.sv
      - hdl/spiRegs.sv
      - hdl/spiTxFifo.sv
      - hdl/spiController.sv
      - hdl/spiShifter.sv
      - hdl/spiPeriph.sv
  - target: test
    files:
      - bench/spiSlaveModel.sv
      - bench/spiTb.sv
